// ==== delta_top.f ====
verilog/delta_pkg.sv
verilog/line_fifo.sv
verilog/region_reader.sv
verilog/vector_subtract.sv
verilog/region_writer.sv
verilog/delta_engine.sv
verilog/mem_arbiter.sv
verilog/delta_top.sv
test/mem_model.sv
test/delta_top_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the delta_top testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module delta_top_tb -Mdir obj_dir -f delta_top.f
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/Vdelta_top_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$log"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$log"; then
    echo "simulation ended without a verdict"
    exit 1
fi
exit 0

// ==== test/delta_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module delta_top_tb
    import delta_pkg::*;
();

    localparam int LANES = 4;
    localparam int LOG2_DEPTH = 3;
    localparam int line_w = LANES * lane_w;
    localparam int mem_depth = 256;
    localparam int slot_lines = 32;
    localparam int num_slots = mem_depth / slot_lines;
    localparam int num_ops = 12;
    localparam int settle_cycles = 20;
    localparam int lane_max = (1 << (lane_w - 1)) - 1;
    localparam int lane_min = -(1 << (lane_w - 1));

    logic clk;
    logic reset;
    logic op_start;
    count_t cfg_count;
    addr_t cfg_left_base;
    addr_t cfg_right_base;
    addr_t cfg_delta_base;
    logic op_done;
    logic mem_req;
    logic mem_we;
    addr_t mem_addr;
    logic [line_w-1:0] mem_wdata;
    logic mem_ack;
    logic [line_w-1:0] mem_rdata;
    int protocol_errors;

    integer seed;
    int value_errors;
    int done_pulses;
    logic plan_ready;
    logic [line_w-1:0] shadow [mem_depth];
    count_t op_count [num_ops];
    addr_t op_left [num_ops];
    addr_t op_right [num_ops];
    addr_t op_delta [num_ops];
    addr_t op_spare [num_ops];
    logic op_extreme [num_ops];
    logic op_poke [num_ops];

    delta_top #(.LANES(LANES), .LOG2_DEPTH(LOG2_DEPTH)) u_dut
    (
        .clk, .reset,
        .op_start, .cfg_count, .cfg_left_base, .cfg_right_base, .cfg_delta_base,
        .op_done,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

    mem_model #(.LANES(LANES), .DEPTH(mem_depth), .SEED(57)) u_mem
    (
        .clk, .reset,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata,
        .protocol_errors
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(negedge clk)
    begin
        if (!reset && op_done)
            done_pulses++;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // each lane is left minus right, clamped to the lane range.
    function automatic lane_t sat_sub(input lane_t a, input lane_t b);
        int diff;
        diff = int'(a) - int'(b);
        if (diff > lane_max)
            diff = lane_max;
        else if (diff < lane_min)
            diff = lane_min;
        return lane_t'(diff);
    endfunction

    function automatic logic [line_w-1:0] delta_of(input logic [line_w-1:0] left,
                                                   input logic [line_w-1:0] right);
        logic [line_w-1:0] result;
        for (int i = 0; i < LANES; i++)
            result[i*lane_w +: lane_w] = sat_sub(left[i*lane_w +: lane_w],
                                                 right[i*lane_w +: lane_w]);
        return result;
    endfunction

    task automatic check_line(input addr_t addr, input logic [line_w-1:0] expected,
                              input logic [line_w-1:0] got);
        if (got !== expected)
        begin
            $display("Fail: time %0t: delta line at %0h expected %h got %h",
                     $time, addr, expected, got);
            value_errors++;
        end
    endtask

    task automatic check_count(input string what, input count_t expected, input count_t got);
        if (got !== expected)
        begin
            $display("Fail: time %0t: %s expected %0d got %0d", $time, what, expected, got);
            value_errors++;
        end
    endtask

    // three or four regions go into distinct slots, so they never overlap.
    task automatic plan_ops();
        int slots [num_slots];
        int pick;
        int tmp;
        int len;
        for (int i = 0; i < num_ops; i++)
        begin
            for (int s = 0; s < num_slots; s++)
                slots[s] = s;
            for (int s = num_slots - 1; s > 0; s--)
            begin
                pick = rand_below(s + 1);
                tmp = slots[s];
                slots[s] = slots[pick];
                slots[pick] = tmp;
            end
            op_extreme[i] = i == 2;
            op_poke[i] = i == 3 || i == 7;
            if (i == 0)
                len = 0;
            else if (i == 1)
                len = 1;
            else if (i == 2)
                len = 3;
            else if (op_poke[i])
                len = 1 + rand_below(20);
            else
                len = rand_below(21);
            op_count[i] = count_t'(len);
            op_left[i] = addr_t'(slots[0] * slot_lines + rand_below(slot_lines - len + 1));
            op_right[i] = addr_t'(slots[1] * slot_lines + rand_below(slot_lines - len + 1));
            op_delta[i] = addr_t'(slots[2] * slot_lines + rand_below(slot_lines - len + 1));
            op_spare[i] = addr_t'(slots[3] * slot_lines);
        end
    endtask

    task automatic fill_memory();
        logic [line_w-1:0] line;
        for (int a = 0; a < mem_depth; a++)
        begin
            for (int i = 0; i < LANES; i++)
                line[i*lane_w +: lane_w] = lane_t'($random(seed));
            shadow[a] = line;
            u_mem.mem[a] = line;
        end
    endtask

    task automatic load_sources(input int op);
        logic [line_w-1:0] left;
        logic [line_w-1:0] right;
        for (int k = 0; k < int'(op_count[op]); k++)
        begin
            for (int i = 0; i < LANES; i++)
            begin
                if (op_extreme[op])
                begin
                    left[i*lane_w +: lane_w] = lane_t'(i % 2 == 0 ? lane_max : lane_min);
                    right[i*lane_w +: lane_w] = lane_t'(i % 2 == 0 ? lane_min : lane_max);
                end
                else
                begin
                    left[i*lane_w +: lane_w] = lane_t'($random(seed));
                    right[i*lane_w +: lane_w] = lane_t'($random(seed));
                end
            end
            shadow[op_left[op] + k] = left;
            shadow[op_right[op] + k] = right;
            u_mem.mem[op_left[op] + k] = left;
            u_mem.mem[op_right[op] + k] = right;
            shadow[op_delta[op] + k] = delta_of(left, right);
        end
    endtask

    task automatic run_op(input int op);
        done_pulses = 0;
        @(posedge clk);
        #2;
        cfg_count = op_count[op];
        cfg_left_base = op_left[op];
        cfg_right_base = op_right[op];
        cfg_delta_base = op_delta[op];
        op_start = 1'b1;
        @(posedge clk);
        #2;
        op_start = 1'b0;
        // a second start while busy points at a spare region that must stay intact.
        if (op_poke[op])
        begin
            repeat (3) @(posedge clk);
            #2;
            cfg_delta_base = op_spare[op];
            op_start = 1'b1;
            @(posedge clk);
            #2;
            op_start = 1'b0;
        end
        wait (done_pulses != 0);
        repeat (settle_cycles) @(posedge clk);
        check_count("op_done pulses", count_t'(1), count_t'(done_pulses));
    endtask

    task automatic check_memory(input int op);
        int stray;
        stray = 0;
        for (int a = 0; a < mem_depth; a++)
        begin
            if (a >= int'(op_delta[op]) && a < int'(op_delta[op]) + int'(op_count[op]))
                check_line(addr_t'(a), shadow[a], u_mem.mem[a]);
            else if (u_mem.mem[a] !== shadow[a])
                stray++;
        end
        check_count("changed words outside the delta region", count_t'(0), count_t'(stray));
    endtask

    // one memory cycle is taken as two clocks, each line costs three transactions.
    initial
    begin
        int limit;
        wait (plan_ready);
        limit = 8 + 20;
        for (int i = 0; i < num_ops; i++)
            limit += 2 * 3 * int'(op_count[i]) * 10 + 100 + settle_cycles;
        repeat (limit) @(posedge clk);
        $display("timeout: the operations did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        seed = 57;
        value_errors = 0;
        done_pulses = 0;
        plan_ready = 1'b0;
        reset = 1'b1;
        op_start = 1'b0;
        cfg_count = '0;
        cfg_left_base = '0;
        cfg_right_base = '0;
        cfg_delta_base = '0;
        plan_ops();
        fill_memory();
        plan_ready = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        for (int i = 0; i < num_ops; i++)
        begin
            load_sources(i);
            run_op(i);
            check_memory(i);
        end
        $display("errors: %0d value mismatches, %0d protocol violations",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/mem_model.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_model
    import delta_pkg::*;
#(
    parameter int LANES = 4,
    parameter int DEPTH = 256,
    parameter int SEED = 57
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      mem_req,
    input  wire                      mem_we,
    input  wire addr_t               mem_addr,
    input  wire [LANES*lane_w-1:0]   mem_wdata,
    output logic                     mem_ack,
    output logic [LANES*lane_w-1:0]  mem_rdata,
    output int                       protocol_errors
);

    logic [LANES*lane_w-1:0] mem [DEPTH];
    integer seed;
    int delay;
    logic waiting;
    logic req_q;
    addr_t addr_q;

    task automatic check_protocol();
        if (mem_req && !req_q && mem_ack)
        begin
            $display("memory port: mem_req rose while mem_ack was still high at %0t", $time);
            protocol_errors++;
        end
        if (mem_req && req_q && mem_addr != addr_q)
        begin
            $display("memory port: mem_addr changed while mem_req was high at %0t", $time);
            protocol_errors++;
        end
    endtask

    task automatic serve();
        if (int'(mem_addr) >= DEPTH)
        begin
            $display("memory port: address %0h is outside the memory at %0t", mem_addr, $time);
            protocol_errors++;
        end
        else if (mem_we)
            mem[mem_addr] = mem_wdata;
        else
            mem_rdata = mem[mem_addr];
    endtask

    // everything is sampled and driven 2 ns after the rising edge, where the
    // registered DUT outputs have settled.
    initial
    begin
        seed = SEED;
        mem_ack = 1'b0;
        mem_rdata = '0;
        protocol_errors = 0;
        waiting = 1'b0;
        req_q = 1'b0;
        addr_q = '0;
        delay = 0;
        forever
        begin
            @(posedge clk);
            #2;
            if (reset)
            begin
                mem_ack = 1'b0;
                waiting = 1'b0;
                req_q = 1'b0;
            end
            else
            begin
                check_protocol();
                if (mem_ack)
                begin
                    if (!mem_req)
                        mem_ack = 1'b0;
                end
                else if (mem_req)
                begin
                    // a fresh request draws its acknowledge delay once.
                    if (!waiting)
                    begin
                        waiting = 1'b1;
                        delay = int'($unsigned($random(seed)) % 8);
                    end
                    if (delay == 0)
                    begin
                        serve();
                        waiting = 1'b0;
                        mem_ack = 1'b1;
                    end
                    else
                        delay--;
                end
                req_q = mem_req;
                addr_q = mem_addr;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/delta_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module delta_top
    import delta_pkg::*;
#(
    parameter int LANES = 4,
    parameter int LOG2_DEPTH = 3
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      op_start,
    input  wire count_t              cfg_count,
    input  wire addr_t               cfg_left_base,
    input  wire addr_t               cfg_right_base,
    input  wire addr_t               cfg_delta_base,
    output logic                     op_done,
    output logic                     mem_req,
    output logic                     mem_we,
    output addr_t                    mem_addr,
    output logic [LANES*lane_w-1:0]  mem_wdata,
    input  wire                      mem_ack,
    input  wire [LANES*lane_w-1:0]   mem_rdata
);

    logic left_req;
    logic left_we;
    addr_t left_addr;
    logic left_ack;
    logic right_req;
    logic right_we;
    addr_t right_addr;
    logic right_ack;
    logic write_req;
    logic write_we;
    addr_t write_addr;
    logic [LANES*lane_w-1:0] write_wdata;
    logic write_ack;
    logic [LANES*lane_w-1:0] cl_rdata;

    delta_engine #(.LANES(LANES), .LOG2_DEPTH(LOG2_DEPTH)) u_engine
    (
        .clk, .reset,
        .op_start, .op_done,
        .cfg_count, .cfg_left_base, .cfg_right_base, .cfg_delta_base,
        .left_req, .left_we, .left_addr, .left_ack,
        .right_req, .right_we, .right_addr, .right_ack,
        .write_req, .write_we, .write_addr, .write_wdata, .write_ack,
        .cl_rdata
    );

    mem_arbiter #(.LANES(LANES)) u_arbiter
    (
        .clk, .reset,
        .left_req, .left_we, .left_addr, .left_ack,
        .right_req, .right_we, .right_addr, .right_ack,
        .write_req, .write_we, .write_addr, .write_wdata, .write_ack,
        .cl_rdata,
        .mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_ack, .mem_rdata
    );

endmodule

`default_nettype wire

// ==== verilog/mem_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter
    import delta_pkg::*;
#(
    parameter int LANES = 4
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      left_req,
    input  wire                      left_we,
    input  wire addr_t               left_addr,
    output logic                     left_ack,
    input  wire                      right_req,
    input  wire                      right_we,
    input  wire addr_t               right_addr,
    output logic                     right_ack,
    input  wire                      write_req,
    input  wire                      write_we,
    input  wire addr_t               write_addr,
    input  wire [LANES*lane_w-1:0]   write_wdata,
    output logic                     write_ack,
    output logic [LANES*lane_w-1:0]  cl_rdata,
    output logic                     mem_req,
    output logic                     mem_we,
    output addr_t                    mem_addr,
    output logic [LANES*lane_w-1:0]  mem_wdata,
    input  wire                      mem_ack,
    input  wire [LANES*lane_w-1:0]   mem_rdata
);

    arb_state_t state;
    mem_client_t grant;
    mem_client_t pick;
    logic [2:0] req_vec;
    logic any_req;
    logic ack_q;

    assign req_vec = {write_req, right_req, left_req};

    assign left_ack = ack_q && grant == client_left;
    assign right_ack = ack_q && grant == client_right;
    assign write_ack = ack_q && grant == client_write;

    // the nearest requester after the last grant wins, so scan from far to near.
    always_comb
    begin
        pick = grant;
        any_req = 1'b0;
        for (int i = 3; i >= 1; i--)
        begin
            if (req_vec[(int'(grant) + i) % 3])
            begin
                pick = mem_client_t'((int'(grant) + i) % 3);
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= arb_idle;
            grant <= client_write;
            mem_req <= 1'b0;
            ack_q <= 1'b0;
        end
        else
        begin
            case (state)
                arb_idle:
                begin
                    if (any_req)
                    begin
                        grant <= pick;
                        mem_req <= 1'b1;
                        state <= arb_busy;
                    end
                end
                arb_busy:
                begin
                    if (mem_ack)
                    begin
                        ack_q <= 1'b1;
                        state <= arb_release;
                    end
                end
                arb_release:
                begin
                    // follow the client down, then wait for the memory to let go.
                    mem_req <= req_vec[grant];
                    if (!mem_req && !mem_ack)
                    begin
                        ack_q <= 1'b0;
                        state <= arb_idle;
                    end
                end
                default:
                    state <= arb_idle;
            endcase
        end
    end

    // the transaction is captured at grant, since a client may move its
    // address as soon as it drops req.
    always_ff @(posedge clk)
    begin
        if (state == arb_idle && any_req)
        begin
            case (pick)
                client_left:
                begin
                    mem_we <= left_we;
                    mem_addr <= left_addr;
                end
                client_right:
                begin
                    mem_we <= right_we;
                    mem_addr <= right_addr;
                end
                default:
                begin
                    mem_we <= write_we;
                    mem_addr <= write_addr;
                end
            endcase
            mem_wdata <= write_wdata;
        end
        if (state == arb_busy && mem_ack)
            cl_rdata <= mem_rdata;
    end

    assert property (@(posedge clk) disable iff (reset)
        !$stable(grant) |-> $past(state) == arb_idle)
        else $error("mem_arbiter: grant changed outside idle");
    assert property (@(posedge clk) disable iff (reset)
        $rose(mem_req) |-> !$past(mem_ack))
        else $error("mem_arbiter: mem_req rose while mem_ack high");

endmodule

`default_nettype wire

// ==== verilog/delta_engine.sv ====
`timescale 1ns/100ps
`default_nettype none

module delta_engine
    import delta_pkg::*;
#(
    parameter int LANES = 4,
    parameter int LOG2_DEPTH = 3
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      op_start,
    output logic                     op_done,
    input  wire count_t              cfg_count,
    input  wire addr_t               cfg_left_base,
    input  wire addr_t               cfg_right_base,
    input  wire addr_t               cfg_delta_base,
    output logic                     left_req,
    output logic                     left_we,
    output addr_t                    left_addr,
    input  wire                      left_ack,
    output logic                     right_req,
    output logic                     right_we,
    output addr_t                    right_addr,
    input  wire                      right_ack,
    output logic                     write_req,
    output logic                     write_we,
    output addr_t                    write_addr,
    output logic [LANES*lane_w-1:0]  write_wdata,
    input  wire                      write_ack,
    input  wire [LANES*lane_w-1:0]   cl_rdata
);

    localparam int line_w = LANES * lane_w;

    engine_state_t state;
    count_t count_q;
    addr_t left_base_q;
    addr_t right_base_q;
    addr_t delta_base_q;
    logic trigger;
    logic left_empty;
    logic right_empty;
    logic room;
    logic pop;
    logic sub_in_valid;
    logic sub_out_valid;
    logic write_done;
    logic [line_w-1:0] left_line;
    logic [line_w-1:0] right_line;
    logic [line_w-1:0] delta_line;

    // both FIFOs advance together, and only while the writer has credit.
    assign pop = (state == engine_process) && !left_empty && !right_empty && room;

    always_ff @(posedge clk)
    begin
        if (state == engine_idle && op_start)
        begin
            count_q <= cfg_count;
            left_base_q <= cfg_left_base;
            right_base_q <= cfg_right_base;
            delta_base_q <= cfg_delta_base;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= engine_idle;
            trigger <= 1'b0;
            op_done <= 1'b0;
            sub_in_valid <= 1'b0;
        end
        else
        begin
            trigger <= 1'b0;
            op_done <= 1'b0;
            sub_in_valid <= pop;
            case (state)
                engine_idle:
                begin
                    if (op_start)
                    begin
                        trigger <= 1'b1;
                        state <= engine_process;
                    end
                end
                engine_process:
                begin
                    // an empty operation has nothing to wait for.
                    if (count_q == '0 || write_done)
                    begin
                        op_done <= 1'b1;
                        state <= engine_idle;
                    end
                end
                default:
                    state <= engine_idle;
            endcase
        end
    end

    region_reader #(.LANES(LANES), .LOG2_DEPTH(LOG2_DEPTH)) u_left_reader
    (
        .clk, .reset,
        .start(trigger), .base(left_base_q), .count(count_q),
        .cl_req(left_req), .cl_we(left_we), .cl_addr(left_addr),
        .cl_ack(left_ack), .cl_rdata,
        .fifo_pop(pop), .fifo_data(left_line), .fifo_empty(left_empty)
    );

    region_reader #(.LANES(LANES), .LOG2_DEPTH(LOG2_DEPTH)) u_right_reader
    (
        .clk, .reset,
        .start(trigger), .base(right_base_q), .count(count_q),
        .cl_req(right_req), .cl_we(right_we), .cl_addr(right_addr),
        .cl_ack(right_ack), .cl_rdata,
        .fifo_pop(pop), .fifo_data(right_line), .fifo_empty(right_empty)
    );

    vector_subtract #(.LANES(LANES)) u_subtract
    (
        .clk, .reset,
        .in_valid(sub_in_valid),
        .left_line, .right_line,
        .out_valid(sub_out_valid),
        .delta_line
    );

    region_writer #(.LANES(LANES), .LOG2_DEPTH(LOG2_DEPTH)) u_writer
    (
        .clk, .reset,
        .start(trigger), .base(delta_base_q), .count(count_q),
        .push(sub_out_valid), .push_data(delta_line), .room,
        .cl_req(write_req), .cl_we(write_we), .cl_addr(write_addr),
        .cl_wdata(write_wdata), .cl_ack(write_ack),
        .done(write_done)
    );

endmodule

`default_nettype wire

// ==== verilog/region_writer.sv ====
`timescale 1ns/100ps
`default_nettype none

module region_writer
    import delta_pkg::*;
#(
    parameter int LANES = 4,
    parameter int LOG2_DEPTH = 3
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      start,
    input  wire addr_t               base,
    input  wire count_t              count,
    input  wire                      push,
    input  wire [LANES*lane_w-1:0]   push_data,
    output logic                     room,
    output logic                     cl_req,
    output logic                     cl_we,
    output addr_t                    cl_addr,
    output logic [LANES*lane_w-1:0]  cl_wdata,
    input  wire                      cl_ack,
    output logic                     done
);

    count_t target;
    count_t written;
    count_t free;
    logic wait_low;
    logic loaded;
    logic fifo_pop;
    logic fifo_empty;

    assign cl_we = 1'b1;

    // up to three lines can still be inside the subtractor.
    assign room = free > count_t'(3);

    assign fifo_pop = !fifo_empty && !loaded && !cl_req && !wait_low;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cl_req <= 1'b0;
            wait_low <= 1'b0;
            loaded <= 1'b0;
            done <= 1'b0;
            written <= '0;
            target <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (start)
            begin
                cl_addr <= base;
                target <= count;
                written <= '0;
            end
            else if (cl_req)
            begin
                if (cl_ack)
                begin
                    cl_req <= 1'b0;
                    wait_low <= 1'b1;
                end
            end
            else if (wait_low)
            begin
                if (!cl_ack)
                begin
                    wait_low <= 1'b0;
                    cl_addr <= cl_addr + 1'b1;
                    written <= written + 1'b1;
                    done <= count_t'(written + 1'b1) == target;
                end
            end
            else if (loaded)
            begin
                // the popped line is on the FIFO output by now.
                loaded <= 1'b0;
                cl_req <= 1'b1;
            end
            else if (fifo_pop)
                loaded <= 1'b1;
        end
    end

    line_fifo #(.LANES(LANES), .LOG2_DEPTH(LOG2_DEPTH)) u_fifo
    (
        .clk,
        .reset,
        .push,
        .push_data,
        .pop(fifo_pop),
        .pop_data(cl_wdata),
        .full(),
        .empty(fifo_empty),
        .free
    );

    assert property (@(posedge clk) disable iff (reset)
        cl_req && $past(cl_req) |-> $stable(cl_wdata))
        else $error("region_writer: write data moved during a request");

endmodule

`default_nettype wire

// ==== verilog/vector_subtract.sv ====
`timescale 1ns/100ps
`default_nettype none

module vector_subtract
    import delta_pkg::*;
#(
    parameter int LANES = 4
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      in_valid,
    input  wire [LANES*lane_w-1:0]   left_line,
    input  wire [LANES*lane_w-1:0]   right_line,
    output logic                     out_valid,
    output logic [LANES*lane_w-1:0]  delta_line
);

    // one extra bit holds any difference of two lanes.
    typedef logic signed [lane_w:0] wide_t;

    wide_t diff_q [LANES];
    logic mid_valid;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            mid_valid <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            mid_valid <= in_valid;
            out_valid <= mid_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < LANES; i++)
        begin
            diff_q[i] <= wide_t'(lane_t'(left_line[i*lane_w +: lane_w]))
                       - wide_t'(lane_t'(right_line[i*lane_w +: lane_w]));
            // the top two bits differ only when the lane range is exceeded.
            if (diff_q[i][lane_w] != diff_q[i][lane_w-1])
                delta_line[i*lane_w +: lane_w] <=
                    {diff_q[i][lane_w], {(lane_w-1){~diff_q[i][lane_w]}}};
            else
                delta_line[i*lane_w +: lane_w] <= diff_q[i][lane_w-1:0];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/region_reader.sv ====
`timescale 1ns/100ps
`default_nettype none

module region_reader
    import delta_pkg::*;
#(
    parameter int LANES = 4,
    parameter int LOG2_DEPTH = 3
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      start,
    input  wire addr_t               base,
    input  wire count_t              count,
    output logic                     cl_req,
    output logic                     cl_we,
    output addr_t                    cl_addr,
    input  wire                      cl_ack,
    input  wire [LANES*lane_w-1:0]   cl_rdata,
    input  wire                      fifo_pop,
    output logic [LANES*lane_w-1:0]  fifo_data,
    output logic                     fifo_empty
);

    count_t remaining;
    count_t free;
    logic wait_low;
    logic fifo_push;

    assign cl_we = 1'b0;

    // req drops on the edge after ack, so this is a single-cycle push.
    assign fifo_push = cl_req && cl_ack;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cl_req <= 1'b0;
            wait_low <= 1'b0;
            remaining <= '0;
        end
        else if (start)
        begin
            cl_addr <= base;
            remaining <= count;
        end
        else if (cl_req)
        begin
            if (cl_ack)
            begin
                cl_req <= 1'b0;
                wait_low <= 1'b1;
                cl_addr <= cl_addr + 1'b1;
                remaining <= remaining - 1'b1;
            end
        end
        else if (wait_low)
        begin
            if (!cl_ack)
                wait_low <= 1'b0;
        end
        else if (remaining != '0 && free != '0)
        begin
            // only one read is ever outstanding, so one free slot is enough.
            cl_req <= 1'b1;
        end
    end

    line_fifo #(.LANES(LANES), .LOG2_DEPTH(LOG2_DEPTH)) u_fifo
    (
        .clk,
        .reset,
        .push(fifo_push),
        .push_data(cl_rdata),
        .pop(fifo_pop),
        .pop_data(fifo_data),
        .full(),
        .empty(fifo_empty),
        .free
    );

    assert property (@(posedge clk) disable iff (reset)
        cl_req && $past(cl_req) |-> $stable(cl_addr))
        else $error("region_reader: address moved during a request");

endmodule

`default_nettype wire

// ==== verilog/line_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module line_fifo
    import delta_pkg::*;
#(
    parameter int LANES = 4,
    parameter int LOG2_DEPTH = 3
)
(
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      push,
    input  wire [LANES*lane_w-1:0]   push_data,
    input  wire                      pop,
    output logic [LANES*lane_w-1:0]  pop_data,
    output logic                     full,
    output logic                     empty,
    output count_t                   free
);

    localparam int depth = 1 << LOG2_DEPTH;

    logic [LANES*lane_w-1:0] storage [depth];
    logic [LOG2_DEPTH-1:0] wr_ptr;
    logic [LOG2_DEPTH-1:0] rd_ptr;
    logic [LOG2_DEPTH:0] used;

    assign full = used == (LOG2_DEPTH+1)'(depth);
    assign empty = used == '0;
    assign free = count_t'(depth) - count_t'(used);

    // the read port is registered, so popped data shows up one cycle later.
    always_ff @(posedge clk)
    begin
        if (push)
            storage[wr_ptr] <= push_data;
        if (pop)
            pop_data <= storage[rd_ptr];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            used <= used + (LOG2_DEPTH+1)'(push) - (LOG2_DEPTH+1)'(pop);
        end
    end

    assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("line_fifo: push while full");
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("line_fifo: pop while empty");

endmodule

`default_nettype wire

// ==== verilog/delta_pkg.sv ====
`default_nettype none

package delta_pkg;

    // width of one lane of a memory line.
    localparam int lane_w = 16;

    typedef logic signed [lane_w-1:0] lane_t;
    typedef logic [15:0] addr_t;
    typedef logic [15:0] count_t;

    // index of a client on the shared memory port.
    typedef logic [1:0] mem_client_t;

    localparam mem_client_t client_left = 2'd0;
    localparam mem_client_t client_right = 2'd1;
    localparam mem_client_t client_write = 2'd2;

    typedef enum logic [1:0]
    {
        arb_idle,
        arb_busy,
        arb_release
    } arb_state_t;

    typedef enum logic
    {
        engine_idle,
        engine_process
    } engine_state_t;

endpackage

`default_nettype wire
